// File: filelist.f
+incdir+design
design/evl_pkg.sv
design/evt_stamper.sv
design/evt_fifo.sv
design/evt_drain.sv
design/evt_logger_top.sv
tb/evt_logger_tb.sv

// File: tb/evt_logger_tb.sv
`include "evl_consts.svh"

// testbench for the event timestamp logger
// cycle model runs on the rising edge, checks run on the falling edge
module evt_logger_tb
    import evl_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int DEPTH        = `EVL_DEPTH;
    localparam int AF           = `EVL_ALMOST_FULL;
    localparam int RESET_CYCLES = 10;
    localparam int T2_EVENTS    = 200;
    localparam int T5_EVENTS    = 300;

    // worst case per test, gaps taken at their maximum
    localparam int STIM_CYCLES = 2 * RESET_CYCLES + 20 + T2_EVENTS * 8
                               + 2 * (DEPTH + 3) + DEPTH + 10
                               + T5_EVENTS * 4 + 2 * DEPTH + 40;
    localparam int TIMEOUT_CYCLES = STIM_CYCLES + 4 * DEPTH + 100;

    logic                   clk;
    logic                   rst;
    logic                   event_valid;
    logic [`EVL_DATA_W-1:0] event_code;
    logic                   drain_en;
    logic                   out_valid;
    evt_out_t               out_rec;
    logic                   fill_warn;
    logic [`EVL_DROP_W-1:0] drop_count;

    // model state
    evt_rec_t                model_q[$];
    evt_out_t                exp_q[$];
    logic [`EVL_STAMP_W-1:0] stamp_m;
    logic [`EVL_STAMP_W-1:0] prev_stamp_m;
    logic [`EVL_DROP_W-1:0]  drops_m;

    logic [15:0] lfsr_state;
    int          check_cnt = 0;
    int          err_cnt   = 0;
    int          test_err0 = 0;
    int          delivered = 0;
    int          cycle_cnt = 0;

    evt_logger_top dut_i (
        .clk         (clk),
        .rst         (rst),
        .event_valid (event_valid),
        .event_code  (event_code),
        .drain_en    (drain_en),
        .out_valid   (out_valid),
        .out_rec     (out_rec),
        .fill_warn   (fill_warn),
        .drop_count  (drop_count)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        logic fb;
        fb = s[15] ^ s[13] ^ s[12] ^ s[10];
        return {s[14:0], fb};
    endfunction

    // one step per bit taken
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    // delivered record for a buffered one
    // interval wraps mod 2^32 like the stamp
    function automatic evt_out_t expected_out(input evt_rec_t rec,
                                              input logic [`EVL_STAMP_W-1:0] prev);
        evt_out_t r;
        r.interval = rec.stamp - prev;
        r.stamp    = rec.stamp;
        r.code     = rec.code;
        return r;
    endfunction

    task automatic check_rec(input evt_out_t got, input evt_out_t want, input string what);
        check_cnt++;
        if (got !== want) begin
            err_cnt++;
            $display("error at %0t ns: %s got interval %0d stamp %0d code %h", $time, what,
                     got.interval, got.stamp, got.code);
            $display("    expected interval %0d stamp %0d code %h",
                     want.interval, want.stamp, want.code);
        end
    endtask

    task automatic check_drops(input logic [`EVL_DROP_W-1:0] got,
                               input logic [`EVL_DROP_W-1:0] want, input string what);
        check_cnt++;
        if (got !== want) begin
            err_cnt++;
            $display("error at %0t ns: %s got %0d expected %0d", $time, what, got, want);
        end
    endtask

    task automatic check_flag(input logic got, input logic want, input string what);
        check_cnt++;
        if (got !== want) begin
            err_cnt++;
            $display("error at %0t ns: %s got %b expected %b", $time, what, got, want);
        end
    endtask

    // cycle model of stamper, buffer and drain
    always @(posedge clk) begin
        evt_rec_t rec;
        logic     was_full;
        if (rst) begin
            model_q.delete();
            exp_q.delete();
            stamp_m      = '0;
            prev_stamp_m = '0;
            drops_m      = '0;
        end else begin
            // registered full, seen before this edge's pop
            was_full = (model_q.size() == DEPTH);
            if (drain_en && model_q.size() != 0) begin
                rec = model_q.pop_front();
                exp_q.push_back(expected_out(rec, prev_stamp_m));
                prev_stamp_m = rec.stamp;
            end
            if (event_valid && !was_full) begin
                rec.stamp = stamp_m;
                rec.code  = event_code;
                model_q.push_back(rec);
            end else if (event_valid && drops_m != '1) begin
                drops_m = drops_m + 1'b1;
            end
            stamp_m = stamp_m + 1'b1;
        end
    end

    // compare DUT outputs with the model mid-cycle
    always @(negedge clk) begin
        evt_out_t want;
        if (out_valid && exp_q.size() == 0) begin
            err_cnt++;
            $display("out_valid at %0t ns while the model has no record to deliver", $time);
        end else if (exp_q.size() != 0) begin
            want = exp_q.pop_front();
            check_flag(out_valid, 1'b1, "out_valid for a popped record");
            if (out_valid) begin
                check_rec(out_rec, want, "delivered record");
                delivered++;
            end
        end
        check_flag(fill_warn, model_q.size() >= DEPTH - AF, "fill_warn");
        check_drops(drop_count, drops_m, "drop_count");
    end

    // run limit
    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    task automatic apply_reset(input int n);
        rst         = 1'b1;
        event_valid = 1'b0;
        repeat (n) @(negedge clk);
        rst = 1'b0;
    endtask

    task automatic idle(input int n);
        repeat (n) @(negedge clk);
    endtask

    // one-cycle strobe
    task automatic send_event(input logic [`EVL_DATA_W-1:0] code);
        event_valid = 1'b1;
        event_code  = code;
        @(negedge clk);
        event_valid = 1'b0;
    endtask

    // needs drain_en high, ends once everything is out
    task automatic wait_drained();
        while (model_q.size() != 0) begin
            @(negedge clk);
        end
        repeat (2) @(negedge clk);
    endtask

    // first event after reset with an empty buffer
    // output exactly 2 cycles after the strobe, interval equal to stamp
    task automatic first_event_check(input logic [`EVL_DATA_W-1:0] code);
        evt_out_t want;
        want.interval = stamp_m;
        want.stamp    = stamp_m;
        want.code     = code;
        send_event(code);
        check_flag(out_valid, 1'b0, "out_valid one cycle after strobe");
        @(negedge clk);
        check_flag(out_valid, 1'b1, "out_valid two cycles after strobe");
        check_rec(out_rec, want, "first record after reset");
    endtask

    task automatic end_test(input string name);
        $display("test %s: %0d errors", name, err_cnt - test_err0);
        test_err0 = err_cnt;
    endtask

    initial begin
        int d0;
        rst         = 1'b1;
        event_valid = 1'b0;
        event_code  = '0;
        drain_en    = 1'b0;
        lfsr_state  = 16'd29;
        apply_reset(RESET_CYCLES);

        drain_en = 1'b1;
        idle(3);
        first_event_check(take_bits(16));
        idle(2);
        end_test("1 single event latency");

        // random gaps of 0 to 7 cycles
        d0 = delivered;
        for (int i = 0; i < T2_EVENTS; i++) begin
            send_event(take_bits(16));
            idle(take_bits(3));
        end
        wait_drained();
        check_flag(delivered == d0 + T2_EVENTS, 1'b1, "all streamed records delivered");
        check_drops(drop_count, '0, "drop_count while streaming");
        end_test("2 streaming with drain on");

        // buffer fills with drain off
        drain_en = 1'b0;
        for (int i = 1; i <= DEPTH + 3; i++) begin
            send_event(take_bits(16));
            check_flag(fill_warn, i >= DEPTH - AF, $sformatf("fill_warn after push %0d", i));
            idle(1);
        end
        check_drops(drop_count, 3, "drop_count after overfill");
        end_test("3 fill warning and drops");

        d0 = delivered;
        drain_en = 1'b1;
        wait_drained();
        check_flag(delivered == d0 + DEPTH, 1'b1, "buffered records delivered");
        // buffer empty, output must stay quiet
        repeat (5) begin
            @(negedge clk);
            check_flag(out_valid, 1'b0, "no out_valid once drained");
        end
        check_flag(fill_warn, 1'b0, "fill_warn once drained");
        end_test("4 drain after back-pressure");

        // drain on about one cycle in four, so the buffer fills and wraps
        for (int i = 0; i < T5_EVENTS; i++) begin
            drain_en = (take_bits(2) == 2'd0);
            send_event(take_bits(16));
            idle(take_bits(2));
        end
        drain_en = 1'b1;
        wait_drained();
        check_drops(drop_count, drops_m, "drop_count against model tally");
        end_test("5 random drain and pointer wrap");

        // reset with records pending and drops counted
        drain_en = 1'b0;
        for (int i = 0; i < DEPTH + 2; i++) begin
            send_event(take_bits(16));
            idle(1);
        end
        check_flag(fill_warn, 1'b1, "fill_warn before reset");
        apply_reset(RESET_CYCLES);
        check_drops(drop_count, '0, "drop_count after reset");
        check_flag(fill_warn, 1'b0, "fill_warn after reset");
        drain_en = 1'b1;
        idle(3);
        first_event_check(take_bits(16));
        idle(2);
        end_test("6 mid-run reset");

        $display("summary: %0d checks, %0d errors, %0d records delivered",
                 check_cnt, err_cnt, delivered);
        if (err_cnt == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// File: design/evt_logger_top.sv
`include "evl_consts.svh"

// event timestamp logger
// stamper feeds the buffer, drain empties it while drain_en is high
module evt_logger_top
    import evl_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,

    // event input
    input  logic                   event_valid,
    input  logic [`EVL_DATA_W-1:0] event_code,

    // drain control
    input  logic                   drain_en,

    // delivered records
    output logic                   out_valid,
    output evt_out_t               out_rec,

    // status
    output logic                   fill_warn,
    output logic [`EVL_DROP_W-1:0] drop_count
);

    // stamper to buffer
    logic     push_en;
    evt_rec_t push_rec;
    logic     full;

    // buffer to drain
    logic     pop_en;
    evt_rec_t pop_rec;
    logic     empty;

    evt_stamper stamper_i (
        .clk         (clk),
        .rst         (rst),
        .event_valid (event_valid),
        .event_code  (event_code),
        .full        (full),
        .push_en     (push_en),
        .push_rec    (push_rec),
        .drop_count  (drop_count)
    );

    // fill_warn comes straight from almost_full
    evt_fifo #(
        .payload_t   (evt_rec_t),
        .DEPTH       (`EVL_DEPTH),
        .ALMOST_FULL (`EVL_ALMOST_FULL)
    ) fifo_i (
        .clk          (clk),
        .rst          (rst),
        .push_en      (push_en),
        .push_data    (push_rec),
        .pop_en       (pop_en),
        .pop_data     (pop_rec),
        .empty        (empty),
        .full         (full),
        .almost_empty (),
        .almost_full  (fill_warn)
    );

    evt_drain drain_i (
        .clk       (clk),
        .rst       (rst),
        .drain_en  (drain_en),
        .empty     (empty),
        .pop_rec   (pop_rec),
        .pop_en    (pop_en),
        .out_valid (out_valid),
        .out_rec   (out_rec)
    );

endmodule

// File: design/evt_drain.sv
`include "evl_consts.svh"

// pops records while drain_en is high
// each popped record leaves as a one-cycle pulse with its interval
module evt_drain
    import evl_pkg::*;
(
    input  logic     clk,
    input  logic     rst,

    // drain control level
    input  logic     drain_en,

    // buffer side
    input  logic     empty,
    input  evt_rec_t pop_rec,
    output logic     pop_en,

    // delivered record
    output logic     out_valid,
    output evt_out_t out_rec
);

    logic [`EVL_STAMP_W-1:0] prev_stamp;

    // pop every cycle data is waiting and draining is allowed
    assign pop_en = drain_en && !empty;

    // stamp of the last delivered record
    // zero after reset so the first interval equals its stamp
    always_ff @(posedge clk) begin
        if (rst) begin
            prev_stamp <= '0;
        end else if (pop_en) begin
            prev_stamp <= pop_rec.stamp;
        end
    end

    // one pulse per pop
    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= pop_en;
        end
    end

    // output record held until the next pop
    // interval wraps modulo 2^32 with the stamp
    always_ff @(posedge clk) begin
        if (pop_en) begin
            out_rec.interval <= pop_rec.stamp - prev_stamp;
            out_rec.stamp    <= pop_rec.stamp;
            out_rec.code     <= pop_rec.code;
        end
    end

    // back-to-back pulses only follow back-to-back pops
    assert property (@(posedge clk) disable iff (rst)
        (out_valid && $past(out_valid)) |-> ($past(pop_en) && $past(pop_en, 2)))
        else $error("evt_drain: out_valid without matching pops");

endmodule

// File: design/evt_fifo.sv
`include "evl_consts.svh"

// first-word-fall-through FIFO with LUT style storage
// oldest entry shows on pop_data whenever empty is low
// depth may be any value from 2 up, not only a power of two
module evt_fifo
    import evl_pkg::*;
#(
    parameter type payload_t   = evt_rec_t,
    parameter int  DEPTH       = `EVL_DEPTH,
    // almost_full once this many free places or fewer remain
    parameter int  ALMOST_FULL = `EVL_ALMOST_FULL
) (
    input  logic     clk,
    input  logic     rst,

    // write side
    input  logic     push_en,
    input  payload_t push_data,

    // read side
    input  logic     pop_en,
    output payload_t pop_data,

    // registered status
    output logic     empty,
    output logic     full,
    output logic     almost_empty,
    output logic     almost_full
);

    localparam int ADDR   = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam bit POWER2 = (DEPTH == (1 << ADDR));

    // almost_empty with one record or none left
    localparam int ALMOST_EMPTY = 1;

    // pointer value one before the last address
    localparam logic [ADDR-1:0] ADDR_PRE_LAST = ADDR'(DEPTH - 2);

    // occupancy thresholds, one extra bit to hold DEPTH itself
    localparam logic [ADDR:0] CNT_ONE      = (ADDR+1)'(1);
    localparam logic [ADDR:0] CNT_FULL_M1  = (ADDR+1)'(DEPTH - 1);
    localparam logic [ADDR:0] CNT_AE       = (ADDR+1)'(ALMOST_EMPTY);
    localparam logic [ADDR:0] CNT_AE_P1    = (ADDR+1)'(ALMOST_EMPTY + 1);
    localparam logic [ADDR:0] CNT_AF_M1    = (ADDR+1)'(DEPTH - ALMOST_FULL - 1);
    localparam logic [ADDR:0] CNT_AF       = (ADDR+1)'(DEPTH - ALMOST_FULL);

    payload_t        mem [DEPTH];
    logic [ADDR-1:0] wr_addr;
    logic [ADDR-1:0] rd_addr;
    logic            wr_addr_last;
    logic            rd_addr_last;
    logic [ADDR:0]   cnt;

    // storage, no reset
    always_ff @(posedge clk) begin
        if (push_en) begin
            mem[wr_addr] <= push_data;
        end
    end

    // fall-through read
    assign pop_data = mem[rd_addr];

    // last-address flags, set one step ahead so the wrap needs no compare
    // power-of-two depth wraps on its own
    generate
        if (!POWER2) begin : g_last
            always_ff @(posedge clk) begin
                if (rst) begin
                    wr_addr_last <= 1'b0;
                end else if (push_en) begin
                    wr_addr_last <= (wr_addr == ADDR_PRE_LAST);
                end
            end

            always_ff @(posedge clk) begin
                if (rst) begin
                    rd_addr_last <= 1'b0;
                end else if (pop_en) begin
                    rd_addr_last <= (rd_addr == ADDR_PRE_LAST);
                end
            end
        end else begin : g_no_last
            assign wr_addr_last = 1'b0;
            assign rd_addr_last = 1'b0;
        end
    endgenerate

    // write pointer
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_addr <= '0;
        end else if (push_en) begin
            wr_addr <= wr_addr_last ? '0 : wr_addr + 1'b1;
        end
    end

    // read pointer
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_addr <= '0;
        end else if (pop_en) begin
            rd_addr <= rd_addr_last ? '0 : rd_addr + 1'b1;
        end
    end

    // occupancy and flags
    // push with pop together leaves everything as it is
    always_ff @(posedge clk) begin
        if (rst) begin
            cnt          <= '0;
            empty        <= 1'b1;
            full         <= 1'b0;
            almost_empty <= 1'b1;
            almost_full  <= 1'b0;
        end else if (push_en && !pop_en) begin
            cnt   <= cnt + 1'b1;
            // never empty after a push
            empty <= 1'b0;
            // count reaches DEPTH
            full  <= (cnt == CNT_FULL_M1);
            if (cnt == CNT_AE) begin
                almost_empty <= 1'b0;
            end
            if (cnt == CNT_AF_M1) begin
                almost_full <= 1'b1;
            end
        end else if (pop_en && !push_en) begin
            cnt   <= cnt - 1'b1;
            // count reaches zero
            empty <= (cnt == CNT_ONE);
            // never full after a pop
            full  <= 1'b0;
            if (cnt == CNT_AE_P1) begin
                almost_empty <= 1'b1;
            end
            if (cnt == CNT_AF) begin
                almost_full <= 1'b0;
            end
        end
    end

    // no push into a full buffer unless a pop frees a place
    assert property (@(posedge clk) disable iff (rst) !(push_en && !pop_en && full))
        else $error("evt_fifo: overflow");

    // no pop from an empty buffer
    assert property (@(posedge clk) disable iff (rst) !(pop_en && empty))
        else $error("evt_fifo: underflow");

endmodule

// File: design/evt_stamper.sv
`include "evl_consts.svh"

// tags each event strobe with the free-running cycle stamp
// events seen while the buffer is full are dropped and counted
module evt_stamper
    import evl_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,

    // event source
    input  logic                   event_valid,
    input  logic [`EVL_DATA_W-1:0] event_code,

    // buffer side
    input  logic                   full,
    output logic                   push_en,
    output evt_rec_t               push_rec,

    // lost events
    output logic [`EVL_DROP_W-1:0] drop_count
);

    logic [`EVL_STAMP_W-1:0] stamp_cnt;

    // free-running stamp
    // zero in the first cycle after reset release
    always_ff @(posedge clk) begin
        if (rst) begin
            stamp_cnt <= '0;
        end else begin
            stamp_cnt <= stamp_cnt + 1'b1;
        end
    end

    // record formed from the current stamp and code
    // written into the buffer at the same edge the strobe is sampled
    always_comb begin
        push_rec.stamp = stamp_cnt;
        push_rec.code  = event_code;
    end

    // decided on registered full only
    // a pop in the same cycle does not rescue the event
    assign push_en = event_valid && !full;

    // saturating count of dropped events
    always_ff @(posedge clk) begin
        if (rst) begin
            drop_count <= '0;
        end else if (event_valid && full && (drop_count != '1)) begin
            drop_count <= drop_count + 1'b1;
        end
    end

    // buffer must never see a write while it reports full
    assert property (@(posedge clk) disable iff (rst) push_en |-> !full)
        else $error("evt_stamper: push while buffer full");

endmodule

// File: design/evl_pkg.sv
package evl_pkg;

`include "evl_consts.svh"

    // one buffered event
    // stamp in the upper bits, code below
    typedef struct packed {
        logic [`EVL_STAMP_W-1:0] stamp;
        logic [`EVL_DATA_W-1:0]  code;
    } evt_rec_t;

    // one delivered event
    // interval is stamp minus previous delivered stamp, mod 2^32
    typedef struct packed {
        logic [`EVL_STAMP_W-1:0] interval;
        logic [`EVL_STAMP_W-1:0] stamp;
        logic [`EVL_DATA_W-1:0]  code;
    } evt_out_t;

endpackage

// File: design/evl_consts.svh
`ifndef EVL_CONSTS_SVH
`define EVL_CONSTS_SVH

// event code width
`define EVL_DATA_W 16
// cycle stamp and interval width
`define EVL_STAMP_W 32
// buffer depth in records, not a power of two on purpose
`define EVL_DEPTH 12
// free places left when fill warning rises
`define EVL_ALMOST_FULL 3
// saturating drop counter width
`define EVL_DROP_W 16

`endif
